// File: branch_resolver.sv
`timescale 1ns/1ps

module branch_resolver import isa_pkg::*; import pipe_pkg::*; (
	input reg_word_t pc_i,
	input reg_word_t reg1_i,
	input reg_word_t reg2_i,
	input inst_word_t inst_i,
	input br_kind_t br_kind_i,
	input logic link_i,
	output logic branch_flag_o,
	output reg_word_t branch_target_o,
	output reg_word_t link_addr_o
);

	reg_word_t pc_plus_4;
	reg_word_t rel_target;

	assign pc_plus_4 = pc_i + 32'd4;
	assign rel_target = pc_plus_4 + {{14{inst_i.i.imm[15]}}, inst_i.i.imm, 2'b00};

	always_comb
	begin
		branch_flag_o = 1'b0;
		branch_target_o = rel_target;
		case (br_kind_i)
			BR_JUMP_ABS:
			begin
				branch_flag_o = 1'b1;
				// Jump index is the low 26 bits of the word
				branch_target_o = {pc_plus_4[31:28], inst_i.i[25:0], 2'b00};
			end
			BR_JUMP_REG:
			begin
				branch_flag_o = 1'b1;
				branch_target_o = reg1_i;
			end
			BR_EQ: branch_flag_o = (reg1_i == reg2_i);
			BR_NE: branch_flag_o = (reg1_i != reg2_i);
			BR_GTZ: branch_flag_o = !reg1_i[31] && (reg1_i != '0);
			BR_LEZ: branch_flag_o = reg1_i[31] || (reg1_i == '0);
			BR_GEZ: branch_flag_o = !reg1_i[31];
			BR_LTZ: branch_flag_o = reg1_i[31];
			default: ;
		endcase
		if (!branch_flag_o)
		begin
			branch_target_o = '0;
		end
	end

	// Return past the delay slot
	assign link_addr_o = link_i ? (pc_i + 32'd8) : '0;

endmodule

// File: id_cases.txt
# pc inst rf1 rf2 ex_wdata mem_wreg mem_wd mem_wdata stall bflag target addr1 addr2
# then after the next edge: aluop wd wreg reg1 reg2 link_addr delayslot (all hex)
# ORI, ADDIU and SLL immediates
400000 34221234 11110000 22220000 0 0 0 0 0 0 0 1 2 25 2 1 11110000 1234 0 0
400004 2483fffe 44440000 33330000 aabbccdd 0 0 0 0 0 0 4 3 56 3 1 44440000 fffffffe 0 0
400008 00062900 0 66660000 0 0 0 0 0 0 0 0 6 7c 5 1 4 66660000 0 0
# OR takes rs from MEM, XOR sees EX and MEM both on rs and takes EX
40000c 01093825 80808080 99990000 0 1 8 8888aaaa 0 0 0 8 9 25 7 1 8888aaaa 99990000 0 0
400010 00eb5026 70707070 bbbb0000 77770000 1 7 7777ffff 0 0 0 7 b 26 a 1 77770000 bbbb0000 0 0
# LW then a dependent ADD, held for one cycle
400014 8dac0000 d0000100 cccc0000 0 0 0 0 0 0 0 d c e3 c 1 d0000100 0 0 0
400018 018f7020 0c0c0c0c ffff0000 0 0 0 0 1 0 0 c f 0 0 0 0 0 0 0
400018 018f7020 0c0c0c0c ffff0000 0 0 0 0 0 0 0 c f 20 e 1 0c0c0c0c ffff0000 0 0
# Taken BEQ, not taken BNE in its delay slot
40001c 10220004 12345678 12345678 0 0 0 0 0 1 400030 1 2 51 0 0 12345678 12345678 0 0
400020 14640008 0000abcd 0000abcd 0 0 0 0 0 0 0 3 4 52 0 0 0000abcd 0000abcd 0 1
# JAL, unknown opcode in its slot, JR through the MEM path
400030 0c100080 0 0 0 0 0 0 0 1 400200 0 10 50 1f 1 0 0 400038 0
400034 fc4a0123 0 0 0 0 0 0 0 0 0 2 a 0 0 0 0 0 0 1
400200 03e00008 deadbeef 0 0 1 1f 400038 0 1 400038 1f 0 8 0 0 400038 0 0 0
400204 3c09beef 0 0 0 0 0 0 0 0 0 0 9 25 9 1 0 beef0000 0 1
400208 01222023 99999999 5 beef0000 0 0 0 0 0 0 9 2 23 4 1 beef0000 5 0 0

// File: id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg import isa_pkg::*; import pipe_pkg::*; (
	input logic clk,
	input logic reset_i,
	input logic stall_i,
	input alu_op_t aluop_i,
	input alu_sel_t alusel_i,
	input reg_word_t reg1_i,
	input reg_word_t reg2_i,
	input reg_addr_t wd_i,
	input logic wreg_i,
	input reg_word_t link_addr_i,
	input logic branch_flag_i,
	input inst_word_t inst_i,
	bypass_if.driver byp,
	output alu_op_t ex_aluop_o,
	output alu_sel_t ex_alusel_o,
	output reg_word_t ex_reg1_o,
	output reg_word_t ex_reg2_o,
	output reg_addr_t ex_wd_o,
	output logic ex_wreg_o,
	output reg_word_t ex_link_addr_o,
	output logic ex_in_delayslot_o,
	output inst_word_t ex_inst_o
);

	// Next accepted instruction is a delay slot
	logic delay_pending;

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			ex_aluop_o <= ALU_NOP;
			ex_alusel_o <= SEL_NOP;
			ex_wreg_o <= 1'b0;
			ex_in_delayslot_o <= 1'b0;
			delay_pending <= 1'b0;
		end
		else if (stall_i)
		begin
			// Bubble, pending flag waits for the held instruction
			ex_aluop_o <= ALU_NOP;
			ex_alusel_o <= SEL_NOP;
			ex_wreg_o <= 1'b0;
			ex_in_delayslot_o <= 1'b0;
		end
		else
		begin
			ex_aluop_o <= aluop_i;
			ex_alusel_o <= alusel_i;
			ex_wreg_o <= wreg_i;
			ex_in_delayslot_o <= delay_pending;
			delay_pending <= branch_flag_i;
		end
	end

	always_ff @(posedge clk)
	begin
		ex_reg1_o <= reg1_i;
		ex_reg2_o <= reg2_i;
		ex_wd_o <= wd_i;
		ex_link_addr_o <= link_addr_i;
		ex_inst_o <= inst_i;
	end

	assign byp.ex_wreg = ex_wreg_o;
	assign byp.ex_wd = ex_wd_o;
	assign byp.ex_is_load = is_load(ex_aluop_o);

endmodule

// File: id_ifaces.sv
`timescale 1ns/1ps

// Register read requests plus the immediate from the decoder
interface operand_req_if import isa_pkg::*; ();

	logic reg1_read;
	logic reg2_read;
	reg_addr_t reg1_addr;
	reg_addr_t reg2_addr;
	reg_word_t imm;

	modport driver (output reg1_read, reg2_read, reg1_addr, reg2_addr, imm);
	modport reader (input reg1_read, reg2_read, reg1_addr, reg2_addr, imm);

endinterface

// Write-back info of the instructions in EX and MEM
interface bypass_if import isa_pkg::*; ();

	logic ex_wreg;
	reg_addr_t ex_wd;
	logic ex_is_load;
	reg_word_t ex_wdata;
	logic mem_wreg;
	reg_addr_t mem_wd;
	reg_word_t mem_wdata;

	// EX fields come from the ID/EX register
	modport driver (output ex_wreg, ex_wd, ex_is_load);
	modport reader (
		input ex_wreg, ex_wd, ex_is_load, ex_wdata,
		input mem_wreg, mem_wd, mem_wdata
	);

endinterface

// File: inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import isa_pkg::*; import pipe_pkg::*; (
	input inst_word_t inst_i,
	operand_req_if.driver req,
	output alu_op_t aluop_o,
	output alu_sel_t alusel_o,
	output reg_addr_t wd_o,
	output logic wreg_o,
	output br_kind_t br_kind_o,
	output logic link_o
);

	logic const_shift;
	reg_word_t imm_ext;

	// SLL, SRL and SRA take the amount from shamt
	assign const_shift = inst_i.r.funct inside {FN_SLL, FN_SRL, FN_SRA};

	assign req.reg1_addr = inst_i.r.rs;
	assign req.reg2_addr = inst_i.r.rt;

	always_comb
	begin
		case (inst_i.i.op)
			OP_LUI: imm_ext = {inst_i.i.imm, 16'h0000};
			OP_ANDI, OP_ORI, OP_XORI: imm_ext = {16'h0000, inst_i.i.imm};
			default: imm_ext = {{16{inst_i.i.imm[15]}}, inst_i.i.imm};
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Operation and result class
	////////////////////////////////////////////////////////////////////////////
	always_comb
	begin
		{aluop_o, alusel_o} = {ALU_NOP, SEL_NOP};
		case (inst_i.r.op)
			OP_SPECIAL:
			begin
				case (inst_i.r.funct)
					FN_OR: {aluop_o, alusel_o} = {ALU_OR, SEL_LOGIC};
					FN_AND: {aluop_o, alusel_o} = {ALU_AND, SEL_LOGIC};
					FN_XOR: {aluop_o, alusel_o} = {ALU_XOR, SEL_LOGIC};
					FN_NOR: {aluop_o, alusel_o} = {ALU_NOR, SEL_LOGIC};
					FN_SLL, FN_SLLV: {aluop_o, alusel_o} = {ALU_SLL, SEL_SHIFT};
					FN_SRL, FN_SRLV: {aluop_o, alusel_o} = {ALU_SRL, SEL_SHIFT};
					FN_SRA, FN_SRAV: {aluop_o, alusel_o} = {ALU_SRA, SEL_SHIFT};
					FN_ADD: {aluop_o, alusel_o} = {ALU_ADD, SEL_ARITH};
					FN_ADDU: {aluop_o, alusel_o} = {ALU_ADDU, SEL_ARITH};
					FN_SUB: {aluop_o, alusel_o} = {ALU_SUB, SEL_ARITH};
					FN_SUBU: {aluop_o, alusel_o} = {ALU_SUBU, SEL_ARITH};
					FN_SLT: {aluop_o, alusel_o} = {ALU_SLT, SEL_ARITH};
					FN_SLTU: {aluop_o, alusel_o} = {ALU_SLTU, SEL_ARITH};
					FN_JR: {aluop_o, alusel_o} = {ALU_JR, SEL_JB};
					FN_JALR: {aluop_o, alusel_o} = {ALU_JALR, SEL_JB};
					default: ;
				endcase
				// rs must be zero for constant shifts, shamt zero otherwise
				if (const_shift ? (inst_i.r.rs != 5'd0) : (inst_i.r.shamt != 5'd0))
				begin
					{aluop_o, alusel_o} = {ALU_NOP, SEL_NOP};
				end
			end
			OP_REGIMM:
			begin
				case (inst_i.i.rt)
					RI_BLTZ: {aluop_o, alusel_o} = {ALU_BLTZ, SEL_JB};
					RI_BGEZ: {aluop_o, alusel_o} = {ALU_BGEZ, SEL_JB};
					RI_BLTZAL: {aluop_o, alusel_o} = {ALU_BLTZAL, SEL_JB};
					RI_BGEZAL: {aluop_o, alusel_o} = {ALU_BGEZAL, SEL_JB};
					default: ;
				endcase
			end
			OP_ORI, OP_LUI: {aluop_o, alusel_o} = {ALU_OR, SEL_LOGIC};
			OP_ANDI: {aluop_o, alusel_o} = {ALU_AND, SEL_LOGIC};
			OP_XORI: {aluop_o, alusel_o} = {ALU_XOR, SEL_LOGIC};
			OP_ADDI: {aluop_o, alusel_o} = {ALU_ADDI, SEL_ARITH};
			OP_ADDIU: {aluop_o, alusel_o} = {ALU_ADDIU, SEL_ARITH};
			OP_SLTI: {aluop_o, alusel_o} = {ALU_SLT, SEL_ARITH};
			OP_SLTIU: {aluop_o, alusel_o} = {ALU_SLTU, SEL_ARITH};
			OP_LB: {aluop_o, alusel_o} = {ALU_LB, SEL_LS};
			OP_LBU: {aluop_o, alusel_o} = {ALU_LBU, SEL_LS};
			OP_LH: {aluop_o, alusel_o} = {ALU_LH, SEL_LS};
			OP_LHU: {aluop_o, alusel_o} = {ALU_LHU, SEL_LS};
			OP_LW: {aluop_o, alusel_o} = {ALU_LW, SEL_LS};
			OP_SB: {aluop_o, alusel_o} = {ALU_SB, SEL_LS};
			OP_SH: {aluop_o, alusel_o} = {ALU_SH, SEL_LS};
			OP_SW: {aluop_o, alusel_o} = {ALU_SW, SEL_LS};
			OP_J: {aluop_o, alusel_o} = {ALU_J, SEL_JB};
			OP_JAL: {aluop_o, alusel_o} = {ALU_JAL, SEL_JB};
			OP_BEQ: {aluop_o, alusel_o} = {ALU_BEQ, SEL_JB};
			OP_BNE: {aluop_o, alusel_o} = {ALU_BNE, SEL_JB};
			OP_BGTZ: {aluop_o, alusel_o} = {ALU_BGTZ, SEL_JB};
			OP_BLEZ: {aluop_o, alusel_o} = {ALU_BLEZ, SEL_JB};
			default: ;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Operand reads, destination and branch kind
	////////////////////////////////////////////////////////////////////////////
	always_comb
	begin
		wd_o = inst_i.r.rd;
		wreg_o = 1'b0;
		br_kind_o = BR_NONE;
		link_o = 1'b0;
		req.reg1_read = 1'b0;
		req.reg2_read = 1'b0;
		req.imm = '0;
		case (alusel_o)
			SEL_LOGIC, SEL_SHIFT, SEL_ARITH:
			begin
				wreg_o = 1'b1;
				if (inst_i.r.op == OP_SPECIAL)
				begin
					req.reg1_read = !const_shift;
					req.reg2_read = 1'b1;
					req.imm = {27'd0, inst_i.r.shamt};
				end
				else
				begin
					wd_o = inst_i.i.rt;
					req.reg1_read = 1'b1;
					req.imm = imm_ext;
				end
			end
			SEL_LS:
			begin
				wreg_o = is_load(aluop_o);
				wd_o = inst_i.i.rt;
				req.reg1_read = 1'b1;
				req.reg2_read = !is_load(aluop_o);
				req.imm = imm_ext;
			end
			SEL_JB:
			begin
				req.reg1_read = 1'b1;
				case (aluop_o)
					ALU_J, ALU_JAL:
					begin
						req.reg1_read = 1'b0;
						br_kind_o = BR_JUMP_ABS;
					end
					ALU_JR, ALU_JALR: br_kind_o = BR_JUMP_REG;
					ALU_BEQ:
					begin
						req.reg2_read = 1'b1;
						br_kind_o = BR_EQ;
					end
					ALU_BNE:
					begin
						req.reg2_read = 1'b1;
						br_kind_o = BR_NE;
					end
					ALU_BGTZ: br_kind_o = BR_GTZ;
					ALU_BLEZ: br_kind_o = BR_LEZ;
					ALU_BGEZ, ALU_BGEZAL: br_kind_o = BR_GEZ;
					ALU_BLTZ, ALU_BLTZAL: br_kind_o = BR_LTZ;
					default: ;
				endcase
				link_o = aluop_o inside {ALU_JAL, ALU_JALR, ALU_BGEZAL, ALU_BLTZAL};
				wreg_o = link_o;
				// JALR links to rd, the rest to r31
				if (link_o && inst_i.r.op != OP_SPECIAL)
				begin
					wd_o = LINK_REG;
				end
			end
			default: ;
		endcase
	end

endmodule

// File: isa_pkg.sv
package isa_pkg;

	typedef logic [31:0] reg_word_t;
	typedef logic [4:0] reg_addr_t;

	localparam reg_addr_t LINK_REG = 5'd31;

	////////////////////////////////////////////////////////////////////////////
	// Primary opcodes
	////////////////////////////////////////////////////////////////////////////
	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_REGIMM = 6'b000001;
	localparam logic [5:0] OP_J = 6'b000010;
	localparam logic [5:0] OP_JAL = 6'b000011;
	localparam logic [5:0] OP_BEQ = 6'b000100;
	localparam logic [5:0] OP_BNE = 6'b000101;
	localparam logic [5:0] OP_BLEZ = 6'b000110;
	localparam logic [5:0] OP_BGTZ = 6'b000111;
	localparam logic [5:0] OP_ADDI = 6'b001000;
	localparam logic [5:0] OP_ADDIU = 6'b001001;
	localparam logic [5:0] OP_SLTI = 6'b001010;
	localparam logic [5:0] OP_SLTIU = 6'b001011;
	localparam logic [5:0] OP_ANDI = 6'b001100;
	localparam logic [5:0] OP_ORI = 6'b001101;
	localparam logic [5:0] OP_XORI = 6'b001110;
	localparam logic [5:0] OP_LUI = 6'b001111;
	localparam logic [5:0] OP_LB = 6'b100000;
	localparam logic [5:0] OP_LH = 6'b100001;
	localparam logic [5:0] OP_LW = 6'b100011;
	localparam logic [5:0] OP_LBU = 6'b100100;
	localparam logic [5:0] OP_LHU = 6'b100101;
	localparam logic [5:0] OP_SB = 6'b101000;
	localparam logic [5:0] OP_SH = 6'b101001;
	localparam logic [5:0] OP_SW = 6'b101011;

	// SPECIAL funct field
	localparam logic [5:0] FN_SLL = 6'b000000;
	localparam logic [5:0] FN_SRL = 6'b000010;
	localparam logic [5:0] FN_SRA = 6'b000011;
	localparam logic [5:0] FN_SLLV = 6'b000100;
	localparam logic [5:0] FN_SRLV = 6'b000110;
	localparam logic [5:0] FN_SRAV = 6'b000111;
	localparam logic [5:0] FN_JR = 6'b001000;
	localparam logic [5:0] FN_JALR = 6'b001001;
	localparam logic [5:0] FN_ADD = 6'b100000;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUB = 6'b100010;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND = 6'b100100;
	localparam logic [5:0] FN_OR = 6'b100101;
	localparam logic [5:0] FN_XOR = 6'b100110;
	localparam logic [5:0] FN_NOR = 6'b100111;
	localparam logic [5:0] FN_SLT = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;

	// REGIMM codes sit in the rt field
	localparam logic [4:0] RI_BLTZ = 5'b00000;
	localparam logic [4:0] RI_BGEZ = 5'b00001;
	localparam logic [4:0] RI_BLTZAL = 5'b10000;
	localparam logic [4:0] RI_BGEZAL = 5'b10001;

	typedef struct packed {
		logic [5:0] op;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_view_t;

	// Low 26 bits double as the J-form jump index
	typedef struct packed {
		logic [5:0] op;
		reg_addr_t rs;
		reg_addr_t rt;
		logic [15:0] imm;
	} i_view_t;

	typedef union packed {
		r_view_t r;
		i_view_t i;
	} inst_word_t;

endpackage

// File: mips_id_top.sv
`timescale 1ns/1ps

module mips_id_top import isa_pkg::*; import pipe_pkg::*; (
	input logic clk,
	input logic reset_i,
	input reg_word_t pc_i,
	input inst_word_t inst_i,
	input reg_word_t reg1_data_i,
	input reg_word_t reg2_data_i,
	input reg_word_t ex_wdata_i,
	input logic mem_wreg_i,
	input reg_addr_t mem_wd_i,
	input reg_word_t mem_wdata_i,
	output logic reg1_read_o,
	output logic reg2_read_o,
	output reg_addr_t reg1_addr_o,
	output reg_addr_t reg2_addr_o,
	output logic stall_o,
	output logic branch_flag_o,
	output reg_word_t branch_target_o,
	output alu_op_t ex_aluop_o,
	output alu_sel_t ex_alusel_o,
	output reg_word_t ex_reg1_o,
	output reg_word_t ex_reg2_o,
	output reg_addr_t ex_wd_o,
	output logic ex_wreg_o,
	output reg_word_t ex_link_addr_o,
	output logic ex_in_delayslot_o,
	output inst_word_t ex_inst_o
);

	operand_req_if req ();
	bypass_if byp ();

	alu_op_t id_aluop;
	alu_sel_t id_alusel;
	reg_addr_t id_wd;
	logic id_wreg;
	br_kind_t id_br_kind;
	logic id_link;
	reg_word_t id_reg1;
	reg_word_t id_reg2;
	reg_word_t id_link_addr;

	// Register file port
	assign reg1_read_o = req.reg1_read;
	assign reg2_read_o = req.reg2_read;
	assign reg1_addr_o = req.reg1_addr;
	assign reg2_addr_o = req.reg2_addr;

	// Forwarding sources from later stages
	assign byp.ex_wdata = ex_wdata_i;
	assign byp.mem_wreg = mem_wreg_i;
	assign byp.mem_wd = mem_wd_i;
	assign byp.mem_wdata = mem_wdata_i;

	inst_decoder u_decoder (
		.inst_i(inst_i),
		.req(req.driver),
		.aluop_o(id_aluop),
		.alusel_o(id_alusel),
		.wd_o(id_wd),
		.wreg_o(id_wreg),
		.br_kind_o(id_br_kind),
		.link_o(id_link)
	);

	operand_bypass u_bypass (
		.req(req.reader),
		.byp(byp.reader),
		.reg1_data_i(reg1_data_i),
		.reg2_data_i(reg2_data_i),
		.reg1_o(id_reg1),
		.reg2_o(id_reg2),
		.stall_o(stall_o)
	);

	branch_resolver u_branch (
		.pc_i(pc_i),
		.reg1_i(id_reg1),
		.reg2_i(id_reg2),
		.inst_i(inst_i),
		.br_kind_i(id_br_kind),
		.link_i(id_link),
		.branch_flag_o(branch_flag_o),
		.branch_target_o(branch_target_o),
		.link_addr_o(id_link_addr)
	);

	id_ex_reg u_id_ex (
		.clk(clk),
		.reset_i(reset_i),
		.stall_i(stall_o),
		.aluop_i(id_aluop),
		.alusel_i(id_alusel),
		.reg1_i(id_reg1),
		.reg2_i(id_reg2),
		.wd_i(id_wd),
		.wreg_i(id_wreg),
		.link_addr_i(id_link_addr),
		.branch_flag_i(branch_flag_o),
		.inst_i(inst_i),
		.byp(byp.driver),
		.ex_aluop_o(ex_aluop_o),
		.ex_alusel_o(ex_alusel_o),
		.ex_reg1_o(ex_reg1_o),
		.ex_reg2_o(ex_reg2_o),
		.ex_wd_o(ex_wd_o),
		.ex_wreg_o(ex_wreg_o),
		.ex_link_addr_o(ex_link_addr_o),
		.ex_in_delayslot_o(ex_in_delayslot_o),
		.ex_inst_o(ex_inst_o)
	);

endmodule

// File: operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass import isa_pkg::*; (
	operand_req_if.reader req,
	bypass_if.reader byp,
	input reg_word_t reg1_data_i,
	input reg_word_t reg2_data_i,
	output reg_word_t reg1_o,
	output reg_word_t reg2_o,
	output logic stall_o
);

	function automatic logic ex_hit(input logic rd_en, input reg_addr_t addr);
		return rd_en && byp.ex_wreg && (byp.ex_wd == addr);
	endfunction

	// EX first, then MEM, then the register file
	function automatic reg_word_t pick(
		input logic rd_en,
		input reg_addr_t addr,
		input reg_word_t rf_data
	);
		if (!rd_en)
			return req.imm;
		if (ex_hit(rd_en, addr))
			return byp.ex_wdata;
		if (byp.mem_wreg && (byp.mem_wd == addr))
			return byp.mem_wdata;
		return rf_data;
	endfunction

	assign reg1_o = pick(req.reg1_read, req.reg1_addr, reg1_data_i);
	assign reg2_o = pick(req.reg2_read, req.reg2_addr, reg2_data_i);

	// Load data not ready until MEM
	assign stall_o = byp.ex_is_load
		&& (ex_hit(req.reg1_read, req.reg1_addr) || ex_hit(req.reg2_read, req.reg2_addr));

endmodule

// File: pipe_pkg.sv
package pipe_pkg;

	typedef logic [7:0] alu_op_t;
	typedef logic [2:0] alu_sel_t;

	////////////////////////////////////////////////////////////////////////////
	// ALU operation codes
	////////////////////////////////////////////////////////////////////////////
	localparam alu_op_t ALU_NOP = 8'b00000000;
	localparam alu_op_t ALU_AND = 8'b00100100;
	localparam alu_op_t ALU_OR = 8'b00100101;
	localparam alu_op_t ALU_XOR = 8'b00100110;
	localparam alu_op_t ALU_NOR = 8'b00100111;
	localparam alu_op_t ALU_SLL = 8'b01111100;
	localparam alu_op_t ALU_SRL = 8'b00000010;
	localparam alu_op_t ALU_SRA = 8'b00000011;
	localparam alu_op_t ALU_SLT = 8'b00101010;
	localparam alu_op_t ALU_SLTU = 8'b00101011;
	localparam alu_op_t ALU_ADD = 8'b00100000;
	localparam alu_op_t ALU_ADDU = 8'b00100001;
	localparam alu_op_t ALU_SUB = 8'b00100010;
	localparam alu_op_t ALU_SUBU = 8'b00100011;
	localparam alu_op_t ALU_ADDI = 8'b01010101;
	localparam alu_op_t ALU_ADDIU = 8'b01010110;
	localparam alu_op_t ALU_J = 8'b01001111;
	localparam alu_op_t ALU_JAL = 8'b01010000;
	localparam alu_op_t ALU_JR = 8'b00001000;
	localparam alu_op_t ALU_JALR = 8'b00001001;
	localparam alu_op_t ALU_BEQ = 8'b01010001;
	localparam alu_op_t ALU_BNE = 8'b01010010;
	localparam alu_op_t ALU_BLEZ = 8'b01010011;
	localparam alu_op_t ALU_BGTZ = 8'b01010100;
	localparam alu_op_t ALU_BGEZ = 8'b01000001;
	localparam alu_op_t ALU_BGEZAL = 8'b01001011;
	localparam alu_op_t ALU_BLTZ = 8'b01000000;
	localparam alu_op_t ALU_BLTZAL = 8'b01001010;
	localparam alu_op_t ALU_LB = 8'b11100000;
	localparam alu_op_t ALU_LH = 8'b11100001;
	localparam alu_op_t ALU_LW = 8'b11100011;
	localparam alu_op_t ALU_LBU = 8'b11100100;
	localparam alu_op_t ALU_LHU = 8'b11100101;
	localparam alu_op_t ALU_SB = 8'b11101000;
	localparam alu_op_t ALU_SH = 8'b11101001;
	localparam alu_op_t ALU_SW = 8'b11101011;

	// Result class
	localparam alu_sel_t SEL_NOP = 3'b000;
	localparam alu_sel_t SEL_LOGIC = 3'b001;
	localparam alu_sel_t SEL_SHIFT = 3'b010;
	localparam alu_sel_t SEL_ARITH = 3'b100;
	localparam alu_sel_t SEL_JB = 3'b110;
	localparam alu_sel_t SEL_LS = 3'b111;

	// Nine kinds, so four bits
	typedef enum logic [3:0] {
		BR_NONE,
		BR_JUMP_ABS,
		BR_JUMP_REG,
		BR_EQ,
		BR_NE,
		BR_GTZ,
		BR_LEZ,
		BR_GEZ,
		BR_LTZ
	} br_kind_t;

	function automatic logic is_load(input alu_op_t op);
		return op inside {ALU_LB, ALU_LBU, ALU_LH, ALU_LHU, ALU_LW};
	endfunction

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tb_mips_id -o sim_tb_mips_id

sim_out=$(./obj_dir/sim_tb_mips_id 2>&1 || true)
echo "$sim_out"

if grep -q "Verification passed" <<< "$sim_out"; then
	exit 0
fi
exit 1

// File: tb_mips_id.sv
`timescale 1ns/1ps

module tb_mips_id import isa_pkg::*; import pipe_pkg::*; ();

	localparam int EDGE_POLLS = 8;
	localparam int RESET_CYCLES = 10;

	// Columns of id_cases.txt
	typedef enum int {
		COL_PC, COL_INST, COL_RF1, COL_RF2, COL_EX_WDATA,
		COL_MEM_WREG, COL_MEM_WD, COL_MEM_WDATA,
		COL_STALL, COL_BFLAG, COL_TARGET, COL_ADDR1, COL_ADDR2,
		COL_ALUOP, COL_WD, COL_WREG, COL_REG1, COL_REG2, COL_LINK, COL_DSLOT,
		NUM_COLS
	} col_t;

	logic clk = 1'b0;
	logic reset_i;
	reg_word_t pc_i;
	inst_word_t inst_i;
	reg_word_t reg1_data_i;
	reg_word_t reg2_data_i;
	reg_word_t ex_wdata_i;
	logic mem_wreg_i;
	reg_addr_t mem_wd_i;
	reg_word_t mem_wdata_i;
	logic reg1_read_o;
	logic reg2_read_o;
	reg_addr_t reg1_addr_o;
	reg_addr_t reg2_addr_o;
	logic stall_o;
	logic branch_flag_o;
	reg_word_t branch_target_o;
	alu_op_t ex_aluop_o;
	alu_sel_t ex_alusel_o;
	reg_word_t ex_reg1_o;
	reg_word_t ex_reg2_o;
	reg_addr_t ex_wd_o;
	logic ex_wreg_o;
	reg_word_t ex_link_addr_o;
	logic ex_in_delayslot_o;
	inst_word_t ex_inst_o;

	int fd;
	int case_count;
	bit have_case;
	logic [31:0] cur [NUM_COLS];
	logic [31:0] prev [NUM_COLS];

	mips_id_top DUT (.*);

	always #2 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "simulation stopped at %0t ns", $time);
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			abort_run($sformatf("error at %0t ns: %s is %h, expected %h",
				$time, name, got, exp));
		end
	endtask

	// Register reads by MIPS operand usage, {reg2, reg1}
	function automatic logic [1:0] expected_reads(input inst_word_t inst);
		case (inst.r.op)
			OP_SPECIAL:
			begin
				case (inst.r.funct)
					FN_SLL, FN_SRL, FN_SRA: return 2'b10;
					FN_JR, FN_JALR: return 2'b01;
					FN_SLLV, FN_SRLV, FN_SRAV, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
					FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU: return 2'b11;
					default: return 2'b00;
				endcase
			end
			OP_REGIMM:
			begin
				if (inst.i.rt inside {RI_BLTZ, RI_BGEZ, RI_BLTZAL, RI_BGEZAL})
					return 2'b01;
				return 2'b00;
			end
			OP_BEQ, OP_BNE, OP_SB, OP_SH, OP_SW: return 2'b11;
			OP_BLEZ, OP_BGTZ, OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI,
			OP_XORI, OP_LUI, OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: return 2'b01;
			default: return 2'b00;
		endcase
	endfunction

	// Result class of an operation
	function automatic alu_sel_t result_class(input logic [31:0] op);
		case (op[7:0])
			ALU_AND, ALU_OR, ALU_XOR, ALU_NOR: return SEL_LOGIC;
			ALU_SLL, ALU_SRL, ALU_SRA: return SEL_SHIFT;
			ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
			ALU_ADDI, ALU_ADDIU: return SEL_ARITH;
			ALU_J, ALU_JAL, ALU_JR, ALU_JALR, ALU_BEQ, ALU_BNE, ALU_BLEZ, ALU_BGTZ,
			ALU_BGEZ, ALU_BGEZAL, ALU_BLTZ, ALU_BLTZAL: return SEL_JB;
			ALU_LB, ALU_LBU, ALU_LH, ALU_LHU, ALU_LW,
			ALU_SB, ALU_SH, ALU_SW: return SEL_LS;
			default: return SEL_NOP;
		endcase
	endfunction

	// Polls at odd ns where the clock never toggles
	// Returns 1 ns after the rising edge
	task automatic wait_clock_rise();
		logic last;
		int polls;
		bit seen;
		seen = 1'b0;
		last = clk;
		for (polls = 0; polls < EDGE_POLLS && !seen; polls++)
		begin
			#2;
			seen = !last && clk;
			last = clk;
		end
		if (!seen)
		begin
			abort_run("timeout while waiting for a rising clock edge");
		end
	endtask

	task automatic read_next_case(output bit found);
		string line;
		int fields;
		found = 1'b0;
		while (!found && !$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 0 && line.getc(0) != "#")
			begin
				fields = $sscanf(line,
					"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					cur[COL_PC], cur[COL_INST], cur[COL_RF1], cur[COL_RF2],
					cur[COL_EX_WDATA], cur[COL_MEM_WREG], cur[COL_MEM_WD],
					cur[COL_MEM_WDATA], cur[COL_STALL], cur[COL_BFLAG],
					cur[COL_TARGET], cur[COL_ADDR1], cur[COL_ADDR2],
					cur[COL_ALUOP], cur[COL_WD], cur[COL_WREG], cur[COL_REG1],
					cur[COL_REG2], cur[COL_LINK], cur[COL_DSLOT]);
				if (fields == NUM_COLS)
				begin
					found = 1'b1;
				end
				else if (fields > 0)
				begin
					abort_run("a line of id_cases.txt has the wrong number of columns");
				end
			end
		end
	endtask

	task automatic drive_case();
		pc_i = cur[COL_PC];
		inst_i = cur[COL_INST];
		reg1_data_i = cur[COL_RF1];
		reg2_data_i = cur[COL_RF2];
		ex_wdata_i = cur[COL_EX_WDATA];
		mem_wreg_i = cur[COL_MEM_WREG][0];
		mem_wd_i = cur[COL_MEM_WD][4:0];
		mem_wdata_i = cur[COL_MEM_WDATA];
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Result checks
	////////////////////////////////////////////////////////////////////////////
	task automatic check_decode_stage();
		logic [1:0] reads;
		reads = expected_reads(cur[COL_INST]);
		compare_value("stall_o", {31'd0, stall_o}, cur[COL_STALL]);
		compare_value("branch_flag_o", {31'd0, branch_flag_o}, cur[COL_BFLAG]);
		compare_value("branch_target_o", branch_target_o, cur[COL_TARGET]);
		compare_value("reg1_read_o", {31'd0, reg1_read_o}, {31'd0, reads[0]});
		compare_value("reg2_read_o", {31'd0, reg2_read_o}, {31'd0, reads[1]});
		compare_value("reg1_addr_o", {27'd0, reg1_addr_o}, cur[COL_ADDR1]);
		compare_value("reg2_addr_o", {27'd0, reg2_addr_o}, cur[COL_ADDR2]);
	endtask

	// Bubble after a stall only defines the control fields
	task automatic check_ex_stage();
		compare_value("ex_aluop_o", {24'd0, ex_aluop_o}, prev[COL_ALUOP]);
		compare_value("ex_alusel_o", {29'd0, ex_alusel_o},
			{29'd0, result_class(prev[COL_ALUOP])});
		compare_value("ex_wreg_o", {31'd0, ex_wreg_o}, prev[COL_WREG]);
		compare_value("ex_in_delayslot_o", {31'd0, ex_in_delayslot_o}, prev[COL_DSLOT]);
		if (prev[COL_STALL] == 32'd0)
		begin
			compare_value("ex_wd_o", {27'd0, ex_wd_o}, prev[COL_WD]);
			compare_value("ex_reg1_o", ex_reg1_o, prev[COL_REG1]);
			compare_value("ex_reg2_o", ex_reg2_o, prev[COL_REG2]);
			compare_value("ex_link_addr_o", ex_link_addr_o, prev[COL_LINK]);
			compare_value("ex_inst_o", ex_inst_o, prev[COL_INST]);
		end
	endtask

	initial
	begin
		reset_i = 1'b1;
		pc_i = '0;
		inst_i = '0;
		reg1_data_i = '0;
		reg2_data_i = '0;
		ex_wdata_i = '0;
		mem_wreg_i = 1'b0;
		mem_wd_i = '0;
		mem_wdata_i = '0;
		case_count = 0;
		fd = $fopen("id_cases.txt", "r");
		if (fd == 0)
		begin
			abort_run("could not open id_cases.txt");
		end
		#1;
		repeat (RESET_CYCLES)
		begin
			wait_clock_rise();
		end
		reset_i = 1'b0;
		read_next_case(have_case);
		if (!have_case)
		begin
			abort_run("id_cases.txt holds no cases");
		end
		// One case per cycle, registered results checked after the next edge
		while (have_case)
		begin
			drive_case();
			#2;
			check_decode_stage();
			prev = cur;
			case_count++;
			read_next_case(have_case);
			wait_clock_rise();
			check_ex_stage();
		end
		$fclose(fd);
		$display("%0d cases checked", case_count);
		$display("Verification passed");
		$finish;
	end

endmodule

// File: verilog.f
isa_pkg.sv
pipe_pkg.sv
id_ifaces.sv
inst_decoder.sv
operand_bypass.sv
branch_resolver.sv
id_ex_reg.sv
mips_id_top.sv
tb_mips_id.sv
